/* include/sys_ctrl_defines.svh */
`ifndef SYS_CTRL_DEFINES_SVH
`define SYS_CTRL_DEFINES_SVH

// Datapath widths
`define SYS_DATA_W 8
`define SYS_ADDR_W 4
`define SYS_FUN_W  4

// First byte of each frame
`define CMD_RF_WRITE  8'hAA
`define CMD_RF_READ   8'hBB
`define CMD_ALU_OPS   8'hCC
`define CMD_ALU_NOOPS 8'hDD

// Operands of a 0xCC frame land here
`define OPERAND_A_ADDR 4'h0
`define OPERAND_B_ADDR 4'h1

`endif

/* rtl/sysCtrlPkg.sv */
package sysCtrlPkg;

`include "sys_ctrl_defines.svh"

    typedef logic [`SYS_DATA_W-1:0] dataByte_t;
    typedef logic [`SYS_ADDR_W-1:0] regAddr_t;
    typedef logic [`SYS_FUN_W-1:0]  aluFun_t;

    // Position of a byte after the command byte
    typedef logic [2:0] byteIndex_t;

    // One-hot frame states
    typedef enum logic [4:0] {
        idle     = 5'b00001,
        rfWrite  = 5'b00010,
        rfRead   = 5'b00100,
        aluOps   = 5'b01000,
        aluNoOps = 5'b10000
    } cmdState_t;

endpackage

/* rtl/sysCtrlIfs.sv */
`timescale 1ns/1ps

// Register file side, all registered in regAccessPort
interface regBusIf import sysCtrlPkg::*; ();
    logic      wrEn;
    logic      rdEn;
    regAddr_t  addr;
    dataByte_t wrData;

    modport master (
        output wrEn,
        output rdEn,
        output addr,
        output wrData
    );

    modport slave (
        input wrEn,
        input rdEn,
        input addr,
        input wrData
    );
endinterface

// Per-byte decode from the sequencer, valid in the rxValid cycle
interface cmdStrobeIf import sysCtrlPkg::*; ();
    dataByte_t frameByte;
    logic      addrLoad;
    logic      wrStrobe;
    logic      rdStrobe;
    logic      funStrobe;
    // Use a reserved operand address, B when operandB is set
    logic      operandSel;
    logic      operandB;
    logic      aluActive;

    modport source (
        output frameByte,
        output addrLoad,
        output wrStrobe,
        output rdStrobe,
        output funStrobe,
        output operandSel,
        output operandB,
        output aluActive
    );

    modport sink (
        input frameByte,
        input addrLoad,
        input wrStrobe,
        input rdStrobe,
        input funStrobe,
        input operandSel,
        input operandB,
        input aluActive
    );
endinterface

/* rtl/frameByteCounter.sv */
`timescale 1ns/1ps

module frameByteCounter import sysCtrlPkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       count,
    input  logic       clear,
    output byteIndex_t byteIndex
);

    // A byte strobe wins over clear
    always_ff @(posedge clk or negedge rst)
    begin
        if (!rst)
        begin
            byteIndex <= '0;
        end
        else if (count)
        begin
            byteIndex <= byteIndex + 3'd1;
        end
        else if (clear)
        begin
            byteIndex <= '0;
        end
    end

endmodule

/* rtl/cmdSequencer.sv */
`timescale 1ns/1ps

`include "sys_ctrl_defines.svh"

module cmdSequencer import sysCtrlPkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  dataByte_t  rxData,
    input  logic       rxValid,
    input  byteIndex_t byteIndex,
    output logic       countClear,
    cmdStrobeIf.source strobes
);

    cmdState_t state;
    cmdState_t nextState;
    cmdState_t cmdTarget;
    logic      cmdHit;
    logic      frameEnd;

    // Command byte lookup
    always_comb
    begin
        cmdHit = 1'b1;
        case (rxData)
            `CMD_RF_WRITE:  cmdTarget = rfWrite;
            `CMD_RF_READ:   cmdTarget = rfRead;
            `CMD_ALU_OPS:   cmdTarget = aluOps;
            `CMD_ALU_NOOPS: cmdTarget = aluNoOps;
            default:
            begin
                cmdTarget = idle;
                cmdHit    = 1'b0;
            end
        endcase
    end

    always_comb
    begin
        strobes.addrLoad   = 1'b0;
        strobes.wrStrobe   = 1'b0;
        strobes.rdStrobe   = 1'b0;
        strobes.funStrobe  = 1'b0;
        strobes.operandSel = 1'b0;
        strobes.operandB   = 1'b0;
        frameEnd           = 1'b0;
        if (rxValid)
        begin
            case (state)
                rfWrite:
                begin
                    if (byteIndex == 3'd1)
                    begin
                        strobes.addrLoad = 1'b1;
                    end
                    else if (byteIndex == 3'd2)
                    begin
                        strobes.wrStrobe = 1'b1;
                        frameEnd         = 1'b1;
                    end
                end
                rfRead:
                begin
                    strobes.addrLoad = 1'b1;
                    strobes.rdStrobe = 1'b1;
                    frameEnd         = 1'b1;
                end
                aluOps:
                begin
                    if (byteIndex == 3'd3)
                    begin
                        strobes.funStrobe = 1'b1;
                        frameEnd          = 1'b1;
                    end
                    else
                    begin
                        // Operand bytes go out as register writes
                        strobes.addrLoad   = 1'b1;
                        strobes.wrStrobe   = 1'b1;
                        strobes.operandSel = 1'b1;
                        strobes.operandB   = (byteIndex == 3'd2);
                    end
                end
                aluNoOps:
                begin
                    strobes.funStrobe = 1'b1;
                    frameEnd          = 1'b1;
                end
                default:
                begin
                    frameEnd = 1'b0;
                end
            endcase
        end
    end

    always_comb
    begin
        if (state == idle)
        begin
            nextState = (rxValid && cmdHit) ? cmdTarget : idle;
        end
        else if (frameEnd)
        begin
            nextState = idle;
        end
        else
        begin
            nextState = state;
        end
    end

    always_ff @(posedge clk or negedge rst)
    begin
        if (!rst)
        begin
            state <= idle;
        end
        else
        begin
            state <= nextState;
        end
    end

    assign countClear        = (state == idle);
    assign strobes.frameByte = rxData;
    // Also high in the command byte cycle so the clock gate opens early
    assign strobes.aluActive = (state == aluOps) || (state == aluNoOps) ||
                               ((nextState == aluOps) || (nextState == aluNoOps));

endmodule

/* rtl/regAccessPort.sv */
`timescale 1ns/1ps

`include "sys_ctrl_defines.svh"

module regAccessPort import sysCtrlPkg::*; (
    input  logic     clk,
    input  logic     rst,
    cmdStrobeIf.sink strobes,
    regBusIf.master  regBus
);

    logic     wrStrobeQ;
    logic     rdStrobeQ;
    regAddr_t nextAddr;

    always_comb
    begin
        if (strobes.operandSel)
        begin
            nextAddr = strobes.operandB ? `OPERAND_B_ADDR : `OPERAND_A_ADDR;
        end
        else
        begin
            nextAddr = strobes.frameByte[`SYS_ADDR_W-1:0];
        end
    end

    // Strobe edges become single-cycle enables
    always_ff @(posedge clk or negedge rst)
    begin
        if (!rst)
        begin
            wrStrobeQ   <= 1'b0;
            rdStrobeQ   <= 1'b0;
            regBus.wrEn <= 1'b0;
            regBus.rdEn <= 1'b0;
        end
        else
        begin
            wrStrobeQ   <= strobes.wrStrobe;
            rdStrobeQ   <= strobes.rdStrobe;
            regBus.wrEn <= strobes.wrStrobe & ~wrStrobeQ;
            regBus.rdEn <= strobes.rdStrobe & ~rdStrobeQ;
        end
    end

    // Address holds between loads
    always_ff @(posedge clk or negedge rst)
    begin
        if (!rst)
        begin
            regBus.addr   <= '0;
            regBus.wrData <= '0;
        end
        else
        begin
            if (strobes.addrLoad)
            begin
                regBus.addr <= nextAddr;
            end
            if (strobes.wrStrobe)
            begin
                regBus.wrData <= strobes.frameByte;
            end
        end
    end

endmodule

/* rtl/aluCommandPort.sv */
`timescale 1ns/1ps

`include "sys_ctrl_defines.svh"

module aluCommandPort import sysCtrlPkg::*; (
    input  logic     clk,
    input  logic     rst,
    cmdStrobeIf.sink strobes,
    input  logic     resultSeen,
    output logic     aluEn,
    output aluFun_t  aluFun,
    output logic     clkGateEn
);

    logic funStrobeQ;
    logic aluActiveQ;
    logic aluOpen;

    assign aluOpen = strobes.aluActive & ~aluActiveQ;

    always_ff @(posedge clk or negedge rst)
    begin
        if (!rst)
        begin
            funStrobeQ <= 1'b0;
            aluEn      <= 1'b0;
            aluFun     <= '0;
        end
        else
        begin
            funStrobeQ <= strobes.funStrobe;
            aluEn      <= strobes.funStrobe & ~funStrobeQ;
            if (strobes.funStrobe)
            begin
                aluFun <= strobes.frameByte[`SYS_FUN_W-1:0];
            end
        end
    end

    // Gate opens with the frame, closes once the result is taken
    always_ff @(posedge clk or negedge rst)
    begin
        if (!rst)
        begin
            aluActiveQ <= 1'b0;
            clkGateEn  <= 1'b0;
        end
        else
        begin
            aluActiveQ <= strobes.aluActive;
            if (aluOpen)
            begin
                clkGateEn <= 1'b1;
            end
            else if (resultSeen)
            begin
                clkGateEn <= 1'b0;
            end
        end
    end

endmodule

/* rtl/responseCapture.sv */
`timescale 1ns/1ps

module responseCapture import sysCtrlPkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  dataByte_t aluResult,
    input  logic      aluResultValid,
    input  dataByte_t rdData,
    input  logic      rdDataValid,
    output dataByte_t txData,
    output logic      txValid,
    output logic      resultSeen
);

    logic aluValidQ;
    logic aluRise;

    // Only the first cycle of a held valid counts
    assign aluRise = aluResultValid & ~aluValidQ;

    always_ff @(posedge clk or negedge rst)
    begin
        if (!rst)
        begin
            aluValidQ  <= 1'b0;
            txData     <= '0;
            txValid    <= 1'b0;
            resultSeen <= 1'b0;
        end
        else
        begin
            aluValidQ  <= aluResultValid;
            txValid    <= aluRise | rdDataValid;
            resultSeen <= aluRise;
            if (aluRise)
            begin
                txData <= aluResult;
            end
            else if (rdDataValid)
            begin
                txData <= rdData;
            end
        end
    end

endmodule

/* rtl/sysCtrl.sv */
`timescale 1ns/1ps

module sysCtrl import sysCtrlPkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  dataByte_t rxData,
    input  logic      rxValid,
    input  dataByte_t aluResult,
    input  logic      aluResultValid,
    input  dataByte_t rdData,
    input  logic      rdDataValid,
    output logic      regWrEn,
    output logic      regRdEn,
    output regAddr_t  regAddr,
    output dataByte_t regWrData,
    output logic      aluEn,
    output aluFun_t   aluFun,
    output logic      clkGateEn,
    output dataByte_t txData,
    output logic      txValid
);

    byteIndex_t byteIndex;
    logic       countClear;
    logic       resultSeen;

    regBusIf    regBus ();
    cmdStrobeIf strobes ();

    cmdSequencer uSequencer (
        .clk        (clk),
        .rst        (rst),
        .rxData     (rxData),
        .rxValid    (rxValid),
        .byteIndex  (byteIndex),
        .countClear (countClear),
        .strobes    (strobes.source)
    );

    // Every received byte counts, idle gaps clear it
    frameByteCounter uCounter (
        .clk       (clk),
        .rst       (rst),
        .count     (rxValid),
        .clear     (countClear),
        .byteIndex (byteIndex)
    );

    regAccessPort uRegPort (
        .clk     (clk),
        .rst     (rst),
        .strobes (strobes.sink),
        .regBus  (regBus.master)
    );

    aluCommandPort uAluPort (
        .clk        (clk),
        .rst        (rst),
        .strobes    (strobes.sink),
        .resultSeen (resultSeen),
        .aluEn      (aluEn),
        .aluFun     (aluFun),
        .clkGateEn  (clkGateEn)
    );

    responseCapture uCapture (
        .clk            (clk),
        .rst            (rst),
        .aluResult      (aluResult),
        .aluResultValid (aluResultValid),
        .rdData         (rdData),
        .rdDataValid    (rdDataValid),
        .txData         (txData),
        .txValid        (txValid),
        .resultSeen     (resultSeen)
    );

    assign regWrEn   = regBus.wrEn;
    assign regRdEn   = regBus.rdEn;
    assign regAddr   = regBus.addr;
    assign regWrData = regBus.wrData;

endmodule

/* dv/sysCtrlProperties.sv */
`timescale 1ns/1ps

`include "sys_ctrl_defines.svh"

module sysCtrlProperties import sysCtrlPkg::*; (
    input logic      clk,
    input logic      rst,
    input dataByte_t rxData,
    input logic      rxValid,
    input logic      aluResultValid,
    input logic      rdDataValid,
    input logic      regWrEn,
    input logic      regRdEn,
    input regAddr_t  regAddr,
    input dataByte_t regWrData,
    input logic      aluEn,
    input aluFun_t   aluFun,
    input logic      clkGateEn,
    input logic      txValid
);

    int unsigned failCount = 0;

    dataByte_t  cmd;
    dataByte_t  addrByte;
    logic [1:0] left;
    logic       aluValidQ;
    logic       aluCaught;

    // Bytes that follow each command byte
    function automatic logic [1:0] frameLen(input dataByte_t b);
        case (b)
            `CMD_RF_WRITE:  return 2'd2;
            `CMD_ALU_OPS:   return 2'd3;
            `CMD_RF_READ:   return 2'd1;
            `CMD_ALU_NOOPS: return 2'd1;
            default:        return 2'd0;
        endcase
    endfunction

    task automatic countFailure(input string what);
        failCount++;
        $error("%s", what);
    endtask

    // Frame position as the receiver sees it
    always_ff @(posedge clk or negedge rst)
    begin
        if (!rst)
        begin
            cmd       <= '0;
            addrByte  <= '0;
            left      <= '0;
            aluValidQ <= 1'b0;
            aluCaught <= 1'b0;
        end
        else
        begin
            aluValidQ <= aluResultValid;
            aluCaught <= aluResultValid & ~aluValidQ;
            if (rxValid && left == 2'd0)
            begin
                cmd  <= rxData;
                left <= frameLen(rxData);
            end
            else if (rxValid)
            begin
                left <= left - 2'd1;
                if (left == 2'd2)
                begin
                    addrByte <= rxData;
                end
            end
        end
    end

    resetQuiet: assert property (@(posedge clk)
        !rst |-> !(regWrEn || regRdEn || aluEn || txValid || clkGateEn))
        else countFailure("pulse output active during reset");

    idleJunk: assert property (@(posedge clk) disable iff (!rst)
        rxValid && left == 2'd0 && frameLen(rxData) == 2'd0 |=> !(regWrEn || regRdEn || aluEn))
        else countFailure("byte outside a frame caused a strobe");

    regWrite: assert property (@(posedge clk) disable iff (!rst)
        rxValid && cmd == `CMD_RF_WRITE && left == 2'd1 |=>
            regWrEn && regAddr == addrByte[`SYS_ADDR_W-1:0] && regWrData == $past(rxData))
        else countFailure("write frame gave a wrong register write");

    regRead: assert property (@(posedge clk) disable iff (!rst)
        rxValid && cmd == `CMD_RF_READ && left == 2'd1 |=>
            regRdEn && !regWrEn && regAddr == $past(rxData[`SYS_ADDR_W-1:0]))
        else countFailure("read frame gave a wrong register read");

    operandWrite: assert property (@(posedge clk) disable iff (!rst)
        rxValid && cmd == `CMD_ALU_OPS && left >= 2'd2 |=>
            regWrEn && regWrData == $past(rxData) &&
            regAddr == (($past(left) == 2'd3) ? `OPERAND_A_ADDR : `OPERAND_B_ADDR))
        else countFailure("ALU operand was not written to its reserved address");

    aluStart: assert property (@(posedge clk) disable iff (!rst)
        rxValid && left == 2'd1 && (cmd == `CMD_ALU_OPS || cmd == `CMD_ALU_NOOPS) |=>
            aluEn && !regWrEn && aluFun == $past(rxData[`SYS_FUN_W-1:0]))
        else countFailure("function byte did not start the ALU");

    gateOpen: assert property (@(posedge clk) disable iff (!rst)
        rxValid && left == 2'd0 && (rxData == `CMD_ALU_OPS || rxData == `CMD_ALU_NOOPS) |=>
            clkGateEn)
        else countFailure("clock gate did not open after an ALU command");

    // Still open in the capture cycle, closed in the next
    gateClose: assert property (@(posedge clk) disable iff (!rst)
        aluCaught |-> clkGateEn ##1 !clkGateEn)
        else countFailure("clock gate did not close one cycle after the ALU result");

    // A held valid is captured once
    heldValid: assert property (@(posedge clk) disable iff (!rst)
        aluResultValid && $past(aluResultValid) && !rdDataValid |=> !txValid)
        else countFailure("held ALU valid was captured again");

    pulseWidth: assert property (@(posedge clk) disable iff (!rst)
        (regWrEn || regRdEn || aluEn) |=> !(regWrEn || regRdEn || aluEn))
        else countFailure("strobe output longer than one cycle");

endmodule

bind sysCtrl sysCtrlProperties props (.*);

/* dv/sysCtrlTb.sv */
`timescale 1ns/1ps

`include "sys_ctrl_defines.svh"

module sysCtrlTb import sysCtrlPkg::*; ();

    localparam int PERIOD       = 40;
    localparam int ROUNDS       = 4;
    localparam int FRAMES       = ROUNDS * 5;
    // Longest frame plus its response
    localparam int FRAME_CYCLES = 16;

    logic      clk;
    logic      rst;
    dataByte_t rxData;
    logic      rxValid;
    dataByte_t aluResult;
    logic      aluResultValid;
    dataByte_t rdData;
    logic      rdDataValid;
    logic      regWrEn;
    logic      regRdEn;
    regAddr_t  regAddr;
    dataByte_t regWrData;
    logic      aluEn;
    aluFun_t   aluFun;
    logic      clkGateEn;
    dataByte_t txData;
    logic      txValid;

    integer seed       = 46268;
    int     errors     = 0;
    int     txChecks   = 0;
    int     wrPulses   = 0;
    int     rdPulses   = 0;
    int     aluPulses  = 0;
    int     gateCloses = 0;
    logic   gateQ      = 1'b0;

    sysCtrl dut (.*);

    initial
    begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    initial
    begin
        #(FRAMES * FRAME_CYCLES * PERIOD + 50 * PERIOD);
        $display("Watchdog expired before the frame sequence finished");
        $display("Test FAILED");
        $finish;
    end

    always @(negedge clk)
    begin
        if (regWrEn) wrPulses++;
        if (regRdEn) rdPulses++;
        if (aluEn) aluPulses++;
        if (gateQ && !clkGateEn) gateCloses++;
        gateQ = clkGateEn;
    end

    task automatic sendByte(input dataByte_t value);
        @(negedge clk);
        rxData  = value;
        rxValid = 1'b1;
        @(negedge clk);
        rxValid = 1'b0;
    endtask

    task automatic sendFrame(input dataByte_t cmd, input dataByte_t p0, input dataByte_t p1,
                             input dataByte_t p2, input int payloadLen);
        sendByte(cmd);
        if (payloadLen > 0) sendByte(p0);
        if (payloadLen > 1) sendByte(p1);
        if (payloadLen > 2) sendByte(p2);
    endtask

    // Transmit pulse expected one cycle after the response input
    task automatic expectTx(input dataByte_t expected);
        if (!txValid)
        begin
            errors++;
            $display("No transmit pulse one cycle after a response input");
        end
        else if (txData !== expected)
        begin
            errors++;
            $display("CHECK FAILED txData expected %h got %h", expected, txData);
        end
        else
        begin
            txChecks++;
        end
    endtask

    task automatic returnReadData(input dataByte_t value);
        @(negedge clk);
        rdData      = value;
        rdDataValid = 1'b1;
        @(negedge clk);
        rdDataValid = 1'b0;
        expectTx(value);
    endtask

    task automatic holdAluResult(input dataByte_t value);
        @(negedge clk);
        aluResult      = value;
        aluResultValid = 1'b1;
        @(negedge clk);
        expectTx(value);
        repeat (3) @(negedge clk);
        aluResultValid = 1'b0;
    endtask

    task automatic requireSeen(input int seen, input string what);
        if (seen == 0)
        begin
            errors++;
            $display("Never reached: %s", what);
        end
    endtask

    initial
    begin
        dataByte_t addr;
        dataByte_t data;
        dataByte_t junk;
        rst            = 1'b0;
        rxData         = '0;
        rxValid        = 1'b0;
        aluResult      = '0;
        aluResultValid = 1'b0;
        rdData         = '0;
        rdDataValid    = 1'b0;
        repeat (3) @(negedge clk);
        rst = 1'b1;
        for (int r = 0; r < ROUNDS; r++)
        begin
            addr = 8'($random(seed));
            data = 8'($random(seed));
            sendFrame(`CMD_RF_WRITE, addr, data, 8'h00, 2);
            sendFrame(`CMD_RF_READ, addr, 8'h00, 8'h00, 1);
            // Register file answers with what was written
            returnReadData(data);
            sendFrame(`CMD_ALU_OPS, 8'($random(seed)), 8'($random(seed)),
                      8'($random(seed)), 3);
            holdAluResult(8'($random(seed)));
            junk = 8'($random(seed));
            if (junk inside {`CMD_RF_WRITE, `CMD_RF_READ, `CMD_ALU_OPS, `CMD_ALU_NOOPS})
            begin
                junk = 8'h5A;
            end
            sendByte(junk);
            sendFrame(`CMD_ALU_NOOPS, 8'($random(seed)), 8'h00, 8'h00, 1);
            holdAluResult(8'($random(seed)));
        end
        repeat (2) @(negedge clk);
        requireSeen(wrPulses, "register write pulse");
        requireSeen(rdPulses, "register read pulse");
        requireSeen(aluPulses, "ALU enable pulse");
        requireSeen(txChecks, "matching transmit data");
        requireSeen(gateCloses, "clock gate closing after a result");
        $display("Errors %0d, assertion failures %0d, tx %0d, wr %0d, rd %0d, alu %0d",
                 errors, dut.props.failCount, txChecks, wrPulses, rdPulses, aluPulses);
        if (errors == 0 && dut.props.failCount == 0)
        begin
            $display("Test OK");
        end
        else
        begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

/* sysCtrl.f */
+incdir+include
rtl/sysCtrlPkg.sv
rtl/sysCtrlIfs.sv
rtl/frameByteCounter.sv
rtl/cmdSequencer.sv
rtl/regAccessPort.sv
rtl/aluCommandPort.sv
rtl/responseCapture.sv
rtl/sysCtrl.sv
dv/sysCtrlProperties.sv
dv/sysCtrlTb.sv

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module sysCtrlTb -f sysCtrl.f -o sysCtrlSim || { echo "Build failed"; exit 1; }
out=$(./obj_dir/sysCtrlSim +verilator+error+limit+100)
echo "$out"
echo "$out" | grep -qx "Test OK" && echo "Simulation passed" || { echo "Simulation failed"; exit 1; }
